/* sources.f */
timer_pkg.sv
button_pkg.sv
debounce.sv
tick_gen.sv
timer_fsm.sv
led_driver.sv
timer_top.sv
tb_timer.sv

/* Makefile */
# Verilator build for the countdown timer
# make lint | make sim | make clean

VERILATOR  ?= verilator
FILELIST   := sources.f
TB_TOP     := tb_timer
RTL_TOP    := timer_top
OBJ_DIR    := obj_dir

LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim build clean

all: sim

# lint the design on its own, then with the testbench around it
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the run is the test result
sim: build
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tb_timer.sv */
/* testbench for timer_top with small parameters so a second is TICK_DIV cycles
   expected led values come from a reference model of the timer rules */
`default_nettype none
`timescale 1ns/1ps

module tb_timer;

    localparam int                TICK_DIV      = 40;
    localparam int                BLINK_BIT     = 2;
    localparam int                DEBOUNCE_BITS = 3;
    localparam timer_pkg::count_t DEF_TIME      = 4'd8;
    localparam int                FLASH_SECS    = 4;

    localparam int WINDOW       = 2 ** DEBOUNCE_BITS;
    localparam int PRESS_CYCLES = 2 * WINDOW + 2;      // two windows plus synchronizer
    localparam int GLITCH_CYCLES = WINDOW - 3;         // well inside one window
    localparam int BLINK_PERIOD = 2 ** (BLINK_BIT + 1);
    localparam int NUM_STEPS    = 17;
    localparam int WATCHDOG_CYCLES = NUM_STEPS * (4 * (PRESS_CYCLES + 3) + 20 * TICK_DIV);

    typedef struct packed {
        button_pkg::button_id_t btn;
        timer_pkg::count_t      exp_led;
        logic                   glitch;   // short pulse, must be ignored
        logic                   done;     // starts a countdown
    } step_t;

    logic                               clk;
    logic                               rst;
    logic [button_pkg::NUM_BUTTONS-1:0] btn;
    timer_pkg::count_t                  led;

    step_t                   steps [NUM_STEPS];
    timer_pkg::timer_state_t model_state;
    timer_pkg::count_t       model_count;
    int unsigned             seed_init;

    timer_top #(
        .TICK_DIV(TICK_DIV),
        .BLINK_BIT(BLINK_BIT),
        .DEBOUNCE_BITS(DEBOUNCE_BITS),
        .DEF_TIME(DEF_TIME),
        .FLASH_SECS(FLASH_SECS)
    ) dut (
        .clk,
        .rst,
        .btn_ctrl(btn[button_pkg::BTN_CTRL]),
        .btn_0(btn[button_pkg::BTN_0]),
        .btn_1(btn[button_pkg::BTN_1]),
        .led
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_led(input timer_pkg::count_t exp, input timer_pkg::count_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: led expected %h, got %h", $time, exp, act));
        end
    endtask

    // all bits together, and a lit pattern must not outlast one blink period
    task automatic check_flash(input timer_pkg::count_t act, input int run_len);
        timer_pkg::count_t exp;
        exp = {timer_pkg::COUNT_W{act[0]}};
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: led expected %b, got %b", $time, exp, act));
        end
        if (act != '0 && run_len > BLINK_PERIOD) begin
            abort_run($sformatf("flash pattern stuck on for %0d cycles at %0t",
                                run_len, $time));
        end
    endtask

    // dark for a full second after the flash
    task automatic check_idle();
        repeat (TICK_DIV) begin
            @(negedge clk);
            check_led('0, led);
        end
    endtask

    // reference model, INIT folded into the control press
    task automatic apply_model(input button_pkg::button_id_t id);
        case (model_state)
            timer_pkg::IDLE: begin
                if (id == button_pkg::BTN_CTRL) begin
                    model_state = timer_pkg::SET_TIME;
                    model_count = DEF_TIME;
                end
            end
            timer_pkg::SET_TIME: begin
                if (id == button_pkg::BTN_0) begin
                    model_count = {model_count[timer_pkg::COUNT_W-2:0], 1'b0};
                end else if (id == button_pkg::BTN_1) begin
                    model_count = {model_count[timer_pkg::COUNT_W-2:0], 1'b1};
                end else begin
                    model_state = timer_pkg::COUNTDOWN;
                end
            end
            default: begin
                // pulses dropped
            end
        endcase
    endtask

    function automatic timer_pkg::count_t model_led();
        if (model_state == timer_pkg::SET_TIME || model_state == timer_pkg::COUNTDOWN) begin
            return model_count;
        end
        return '0;
    endfunction

    task automatic press(input button_pkg::button_id_t id, input int hold);
        btn[id] = 1'b1;
        repeat (hold) @(negedge clk);
        btn[id] = 1'b0;
    endtask

    // follows led from the control release down to zero
    task automatic watch_countdown();
        int  gap;
        bit  first;
        gap   = 0;
        first = 1'b1;
        while (model_count != '0) begin
            @(negedge clk);
            gap++;
            if (led != model_count) begin
                check_led(model_count - 1'b1, led);
                if (!first && (gap < TICK_DIV - 1 || gap > TICK_DIV + 1)) begin
                    abort_run($sformatf("countdown step took %0d cycles, expected about %0d",
                                        gap, TICK_DIV));
                end
                model_count = model_count - 1'b1;
                gap         = 0;
                first       = 1'b0;
            end else if (gap > 2 * TICK_DIV + PRESS_CYCLES) begin
                abort_run($sformatf("countdown stalled at %0d", model_count));
            end
        end
        model_state = timer_pkg::DONE;
    endtask

    task automatic watch_flash();
        int                cycles;
        int                zero_run;
        int                run;
        int                first_on;
        int                last_on;
        int                span;
        bit                seen_on;
        timer_pkg::count_t prev;
        cycles   = 0;
        zero_run = 0;
        run      = 0;
        first_on = 0;
        last_on  = 0;
        seen_on  = 1'b0;
        prev     = led;
        while (!(seen_on && zero_run > BLINK_PERIOD)) begin
            @(negedge clk);
            cycles++;
            run  = (led == prev) ? run + 1 : 1;
            prev = led;
            check_flash(led, run);
            if (led != '0) begin
                if (!seen_on) begin
                    first_on = cycles;
                end
                seen_on  = 1'b1;
                last_on  = cycles;
                zero_run = 0;
            end else begin
                zero_run++;
            end
            if (cycles > (FLASH_SECS + 2) * TICK_DIV) begin
                abort_run("flash never started or never ended");
            end
        end
        span = last_on - first_on;
        if (span < (FLASH_SECS - 1) * TICK_DIV - BLINK_PERIOD ||
            span > (FLASH_SECS + 1) * TICK_DIV) begin
            abort_run($sformatf("flash lasted %0d cycles, expected about %0d",
                                span, FLASH_SECS * TICK_DIV));
        end
        model_state = timer_pkg::IDLE;
        model_count = '0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout: test did not finish within %0d cycles",
                            WATCHDOG_CYCLES));
    end

    initial begin
        step_t step;
        int    hold;
        steps[0]  = '{button_pkg::BTN_0,    4'd0,  1'b0, 1'b0};  // idle ignores data
        steps[1]  = '{button_pkg::BTN_1,    4'd0,  1'b0, 1'b0};
        steps[2]  = '{button_pkg::BTN_CTRL, 4'd8,  1'b0, 1'b0};
        steps[3]  = '{button_pkg::BTN_1,    4'd1,  1'b0, 1'b0};
        steps[4]  = '{button_pkg::BTN_0,    4'd2,  1'b0, 1'b0};
        steps[5]  = '{button_pkg::BTN_1,    4'd5,  1'b0, 1'b0};
        steps[6]  = '{button_pkg::BTN_1,    4'd11, 1'b0, 1'b0};
        steps[7]  = '{button_pkg::BTN_0,    4'd11, 1'b1, 1'b0};
        steps[8]  = '{button_pkg::BTN_CTRL, 4'd11, 1'b1, 1'b0};
        steps[9]  = '{button_pkg::BTN_CTRL, 4'd0,  1'b0, 1'b1};  // count down from 11
        steps[10] = '{button_pkg::BTN_CTRL, 4'd8,  1'b0, 1'b0};
        steps[11] = '{button_pkg::BTN_0,    4'd0,  1'b0, 1'b0};
        steps[12] = '{button_pkg::BTN_0,    4'd0,  1'b0, 1'b0};
        steps[13] = '{button_pkg::BTN_0,    4'd0,  1'b0, 1'b0};
        steps[14] = '{button_pkg::BTN_0,    4'd0,  1'b0, 1'b0};
        steps[15] = '{button_pkg::BTN_CTRL, 4'd0,  1'b0, 1'b1};  // zero start
        steps[16] = '{button_pkg::BTN_CTRL, 4'd8,  1'b0, 1'b0};

        seed_init   = $urandom(32'h9b6a);
        btn         = '0;
        rst         = 1'b1;
        model_state = timer_pkg::IDLE;
        model_count = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_led('0, led);

        for (int i = 0; i < NUM_STEPS; i++) begin
            step = steps[i];
            if (step.glitch) begin
                press(step.btn, GLITCH_CYCLES);
                // long enough for a tick to show a started countdown
                repeat (PRESS_CYCLES + TICK_DIV) @(negedge clk);
                check_led(step.exp_led, led);
            end else begin
                apply_model(step.btn);
                hold = PRESS_CYCLES + int'($urandom % 4);
                press(step.btn, hold);
                if (step.done) begin
                    if (model_state != timer_pkg::COUNTDOWN) begin
                        abort_run($sformatf("table row %0d starts no countdown in the model", i));
                    end
                    watch_countdown();
                    watch_flash();
                    check_idle();
                end else begin
                    repeat (PRESS_CYCLES + int'($urandom % 4)) @(negedge clk);
                    if (model_led() != step.exp_led) begin
                        abort_run($sformatf("table row %0d disagrees with the reference model", i));
                    end
                    check_led(step.exp_led, led);
                end
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* timer_top.sv */
/* countdown timer top: three buttons in, four LEDs out
   defaults suit a 100 MHz board clock; buttons are active high */
`default_nettype none
`timescale 1ns/1ps

module timer_top #(
    parameter int                TICK_DIV      = 100_000_000,
    parameter int                BLINK_BIT     = 23,
    parameter int                DEBOUNCE_BITS = 16,
    parameter timer_pkg::count_t DEF_TIME      = 4'd8,
    parameter int                FLASH_SECS    = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              btn_ctrl,
    input  logic              btn_0,
    input  logic              btn_1,
    output timer_pkg::count_t led
);

    logic [button_pkg::NUM_BUTTONS-1:0] up;  // release pulses, indexed by button id
    logic                               tick;
    logic                               blink;
    timer_pkg::timer_state_t            state;
    timer_pkg::count_t                  count;

    debounce #(.DEBOUNCE_BITS(DEBOUNCE_BITS)) deb_ctrl (
        .clk, .rst, .in(btn_ctrl), .out(), .up(up[button_pkg::BTN_CTRL])
    );
    debounce #(.DEBOUNCE_BITS(DEBOUNCE_BITS)) deb_0 (
        .clk, .rst, .in(btn_0), .out(), .up(up[button_pkg::BTN_0])
    );
    debounce #(.DEBOUNCE_BITS(DEBOUNCE_BITS)) deb_1 (
        .clk, .rst, .in(btn_1), .out(), .up(up[button_pkg::BTN_1])
    );

    tick_gen #(.TICK_DIV(TICK_DIV), .BLINK_BIT(BLINK_BIT)) u_tick_gen (
        .clk, .rst, .tick, .blink
    );

    timer_fsm #(.DEF_TIME(DEF_TIME), .FLASH_SECS(FLASH_SECS)) u_timer_fsm (
        .clk, .rst,
        .up_ctrl(up[button_pkg::BTN_CTRL]),
        .up_0(up[button_pkg::BTN_0]),
        .up_1(up[button_pkg::BTN_1]),
        .tick, .state, .count
    );

    led_driver u_led_driver (
        .clk, .rst, .state, .count, .blink, .led
    );

endmodule

`default_nettype wire

/* led_driver.sv */
/* registered LED pattern, one cycle behind state and count
   blink drives all four LEDs together while done */
`default_nettype none
`timescale 1ns/1ps

module led_driver (
    input  logic                    clk,
    input  logic                    rst,
    input  timer_pkg::timer_state_t state,
    input  timer_pkg::count_t       count,
    input  logic                    blink,
    output timer_pkg::count_t       led
);

    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
        end else begin
            case (state)
                timer_pkg::SET_TIME,
                timer_pkg::COUNTDOWN: begin
                    led <= count;  // show the time value
                end
                timer_pkg::DONE: begin
                    led <= {timer_pkg::COUNT_W{blink}};
                end
                default: begin
                    led <= '0;  // idle and init stay dark
                end
            endcase
        end
    end

    // flash pattern reaches the pins intact
    a_done_uniform: assert property (
        @(posedge clk) disable iff (rst)
        (state == timer_pkg::DONE) |=> (led == '0 || led == '1)
    );

endmodule

`default_nettype wire

/* timer_fsm.sv */
/* timer state machine, holds the time value and the done flash counter
   button inputs are single-cycle pulses; pulses in states that ignore them are dropped
   count does not wrap below zero */
`default_nettype none
`timescale 1ns/1ps

module timer_fsm #(
    parameter timer_pkg::count_t DEF_TIME   = 4'd8,
    parameter int                FLASH_SECS = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    up_ctrl,
    input  logic                    up_0,
    input  logic                    up_1,
    input  logic                    tick,
    output timer_pkg::timer_state_t state,
    output timer_pkg::count_t       count
);

    localparam int FLASH_W = $clog2(FLASH_SECS + 1);

    timer_pkg::timer_state_t state_next;
    logic [FLASH_W-1:0]      flash_cnt;  // done seconds left

    // next state
    always_comb begin
        case (state)
            timer_pkg::IDLE: begin
                state_next = up_ctrl ? timer_pkg::INIT : timer_pkg::IDLE;
            end
            timer_pkg::INIT: begin
                state_next = timer_pkg::SET_TIME;
            end
            timer_pkg::SET_TIME: begin
                state_next = up_ctrl ? timer_pkg::COUNTDOWN : timer_pkg::SET_TIME;
            end
            timer_pkg::COUNTDOWN: begin
                // zero may already be set, leave at once
                state_next = (count == '0) ? timer_pkg::DONE : timer_pkg::COUNTDOWN;
            end
            timer_pkg::DONE: begin
                state_next = (flash_cnt == '0) ? timer_pkg::IDLE : timer_pkg::DONE;
            end
            default: begin
                state_next = timer_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= timer_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // time value and flash counter
    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            flash_cnt <= '0;
        end else begin
            case (state)
                timer_pkg::INIT: begin
                    count     <= DEF_TIME;
                    flash_cnt <= FLASH_W'(FLASH_SECS);
                end
                timer_pkg::SET_TIME: begin
                    if (up_0) begin
                        count <= {count[timer_pkg::COUNT_W-2:0], 1'b0};  // 0 wins a tie
                    end else if (up_1) begin
                        count <= {count[timer_pkg::COUNT_W-2:0], 1'b1};
                    end
                end
                timer_pkg::COUNTDOWN: begin
                    if (tick && count != '0) begin
                        count <= count - 1'b1;
                    end
                end
                timer_pkg::DONE: begin
                    if (flash_cnt == '0) begin
                        count <= '0;  // leaving for idle
                    end else if (tick) begin
                        flash_cnt <= flash_cnt - 1'b1;
                    end
                end
                default: begin
                    // idle holds everything
                end
            endcase
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {timer_pkg::IDLE, timer_pkg::INIT, timer_pkg::SET_TIME,
                      timer_pkg::COUNTDOWN, timer_pkg::DONE}
    );

    // count is frozen once the countdown has ended and until the next INIT
    a_count_frozen: assert property (
        @(posedge clk) disable iff (rst)
        (state == timer_pkg::DONE || state == timer_pkg::IDLE) |=> $stable(count)
    );

endmodule

`default_nettype wire

/* tick_gen.sv */
/* free running one-second strobe, TICK_DIV clock cycles per tick
   needs TICK_DIV > 1 and BLINK_BIT below the counter width */
`default_nettype none
`timescale 1ns/1ps

module tick_gen #(
    parameter int TICK_DIV  = 100_000_000,
    parameter int BLINK_BIT = 23
) (
    input  logic clk,
    input  logic rst,
    output logic tick,
    output logic blink
);

    localparam int CNT_W = $clog2(TICK_DIV);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == CNT_W'(TICK_DIV - 1)) begin
            cnt  <= '0;  // wrap
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    // flash rate for the done pattern
    assign blink = cnt[BLINK_BIT];

    // strobe, never a level
    a_tick_one_cycle: assert property (
        @(posedge clk) disable iff (rst) tick |=> !tick
    );

endmodule

`default_nettype wire

/* debounce.sv */
/* one button: two-flop synchronizer, then a 2**DEBOUNCE_BITS cycle stability window
   button level is active high (1 = pressed); up pulses for one cycle on release */
`default_nettype none
`timescale 1ns/1ps

module debounce #(
    parameter int DEBOUNCE_BITS = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic in,
    output logic out,
    output logic up
);

    logic sync_0;
    logic sync_1;
    logic [DEBOUNCE_BITS-1:0] cnt;  // cycles the synced level has differed

    // bring the raw pin into the clock domain
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
        end else begin
            sync_0 <= in;
            sync_1 <= sync_0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            out <= 1'b0;
            up  <= 1'b0;
        end else begin
            up <= 1'b0;
            if (sync_1 == out) begin
                cnt <= '0;  // agrees again, restart window
            end else if (cnt == '1) begin
                // held for the full window
                cnt <= '0;
                out <= sync_1;
                up  <= ~sync_1;  // pressed -> released
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // a release needs a full window after the flip, so pulses never touch
    a_up_single: assert property (@(posedge clk) disable iff (rst) up |=> !up);

endmodule

`default_nettype wire

/* button_pkg.sv */
/* button identities, shared by the input side and the testbench
   values double as indices into per-button signal vectors */
`default_nettype none

package button_pkg;

    // number of push buttons on the board
    localparam int NUM_BUTTONS = 3;

    typedef enum logic [1:0] {
        BTN_CTRL,  // steps the timer
        BTN_0,     // shifts in a 0
        BTN_1      // shifts in a 1
    } button_id_t;

endpackage

`default_nettype wire

/* timer_pkg.sv */
/* timer core types: state encoding and the time value
   COUNT_W is fixed by the four LEDs on the board */
`default_nettype none

package timer_pkg;

    // time value width, one bit per LED
    localparam int COUNT_W = 4;

    typedef logic [COUNT_W-1:0] count_t;

    // timer steps, in the order the control button walks them
    typedef enum logic [2:0] {
        IDLE,       // dark, waiting for control press
        INIT,       // load default time and flash length
        SET_TIME,   // data buttons shift bits in
        COUNTDOWN,  // one decrement per tick
        DONE        // all LEDs flash
    } timer_state_t;

endpackage

`default_nettype wire
